//--- common/snes_pkg.sv
package snes_pkg;

  // rom and ram address mask width, covers the full 24-bit cart bus
  localparam int MASK_W = 24;

  // work memory sweep, 128 KiB of byte addresses
  localparam int FILL_ADDR_W = 17;

  // 1 KiB unit, shifted left by a header size code
  localparam logic [MASK_W-1:0] SIZE_BASE = 24'd1024;

  // parser delay start count after download ends
  localparam logic [2:0] PARSER_DELAY = 3'd6;

  // battery ram is always cleared to erased flash value
  localparam logic [7:0] BSRAM_FILL = 8'hFF;

  // one pad read, 12 buttons plus 4 id bits
  localparam int PAD_BITS = 16;

  // size codes as read from the cart header
  typedef struct packed {
    logic [3:0] rom_size;
    logic [3:0] ram_size;
  } cart_header_t;

  // clear pattern select, same encoding for work and audio ram
  typedef enum logic [1:0] {
    fill_checker = 2'd0,
    fill_stripe  = 2'd1,
    fill_const55 = 2'd2,
    fill_constff = 2'd3
  } fill_pattern_e;

  typedef struct packed {
    fill_pattern_e wram_pattern;
    fill_pattern_e aram_pattern;
  } fill_cfg_t;

  // one write of the clear sweep to all three rams
  typedef struct packed {
    logic                   we;
    logic [FILL_ADDR_W-1:0] addr;
    logic [7:0]             wram_data;
    logic [7:0]             aram_data;
    logic [7:0]             bsram_data;
  } mem_fill_t;

  // buttons, high when pressed, listed in console serial order
  typedef struct packed {
    logic b;
    logic y;
    logic select;
    logic start;
    logic up;
    logic down;
    logic left;
    logic right;
    logic a;
    logic x;
    logic l;
    logic r;
  } pad_buttons_t;

endpackage

//--- hdl/cart_loader.sv
`timescale 1ns/1ps

module cart_loader import snes_pkg::*; (
  input  logic              clk_sys,
  input  logic              reset,
  input  logic              cart_download,
  input  cart_header_t      cart_header,
  input  logic              clearing,
  output logic              clear_start,
  output logic              core_reset_n,
  output logic [MASK_W-1:0] rom_mask,
  output logic [MASK_W-1:0] ram_mask,
  output logic [3:0]        sram_size
);

  // previous download level for edge detect
  logic       download_q;
  logic       download_rise;
  logic       download_fall;
  // parser delay countdown, idle at zero
  logic [2:0] delay_cnt;
  // free running phase for reset release
  logic [1:0] phase;
  logic       hold;

  assign download_rise = cart_download & ~download_q;
  assign download_fall = ~cart_download & download_q;

  // core stays in reset for any of these
  assign hold = ~reset | cart_download | clearing | (delay_cnt != 3'd0);

  // edge detect and clear request
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      download_q  <= 1'b0;
      clear_start <= 1'b0;
    end else begin
      download_q  <= cart_download;
      // single pulse, one cycle after the rising edge
      clear_start <= download_rise;
    end
  end

  // parser delay, header settles while this runs
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      delay_cnt <= 3'd0;
    end else if (download_fall) begin
      delay_cnt <= PARSER_DELAY;
    end else if (delay_cnt != 3'd0) begin
      delay_cnt <= delay_cnt - 3'd1;
    end
  end

  // masks latched one cycle before the count expires
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      rom_mask  <= '0;
      ram_mask  <= '0;
      sram_size <= 4'd0;
    end else if (delay_cnt == 3'd1) begin
      rom_mask <= (SIZE_BASE << cart_header.rom_size) - MASK_W'(1);
      // no save ram at all for size code 0
      if (cart_header.ram_size != 4'd0) begin
        ram_mask <= (SIZE_BASE << cart_header.ram_size) - MASK_W'(1);
      end else begin
        ram_mask <= '0;
      end
      sram_size <= cart_header.ram_size;
    end
  end

  // reset release only on phase 2
  // so the core always starts on the same clock phase
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      phase        <= 2'd0;
      core_reset_n <= 1'b0;
    end else begin
      phase <= phase + 2'd1;
      if (phase == 2'd2) begin
        core_reset_n <= ~hold;
      end
    end
  end

endmodule

//--- mem_clear/ram_clear.sv
`timescale 1ns/1ps

module ram_clear import snes_pkg::*; (
  input  logic      clk_sys,
  input  logic      reset,
  input  logic      clear_start,
  input  fill_cfg_t fill_cfg,
  output logic      clearing,
  output mem_fill_t mem_fill
);

  // sweep address, one byte of each ram per write
  logic [FILL_ADDR_W-1:0] addr;
  // write pace divider, stands in for the psram write rate
  logic [1:0]             div;
  logic                   fill_we;

  // fill byte for one pattern at one address
  function automatic logic [7:0] fill_byte(input fill_pattern_e pat,
                                           input logic [FILL_ADDR_W-1:0] a);
    logic [7:0] val;
    case (pat)
      // checkerboard on bits 8 and 2
      fill_checker: val = (a[8] ^ a[2]) ? 8'h66 : 8'h99;
      // stripes on bits 9 and 0
      fill_stripe:  val = (a[9] ^ a[0]) ? 8'hFF : 8'h00;
      fill_const55: val = 8'h55;
      default:      val = 8'hFF;
    endcase
    return val;
  endfunction

  // one write every fourth clock while clearing
  assign fill_we = clearing & (div == 2'd0);

  // divider keeps running between clears
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      div <= 2'd0;
    end else begin
      div <= div + 2'd1;
    end
  end

  // clearing flag and address stepping
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      clearing <= 1'b0;
      addr     <= '0;
    end else if (clear_start) begin
      // a new download restarts the sweep
      clearing <= 1'b1;
      addr     <= '0;
    end else if (fill_we) begin
      if (&addr) begin
        // last address written, sweep done
        clearing <= 1'b0;
        addr     <= '0;
      end else begin
        addr <= addr + FILL_ADDR_W'(1);
      end
    end
  end

  // write bus to the rams
  always_comb begin
    mem_fill.we         = fill_we;
    mem_fill.addr       = addr;
    mem_fill.wram_data  = fill_byte(fill_cfg.wram_pattern, addr);
    mem_fill.aram_data  = fill_byte(fill_cfg.aram_pattern, addr);
    // battery ram ignores the pattern setting
    mem_fill.bsram_data = BSRAM_FILL;
  end

endmodule

//--- joypad/joypad_port.sv
`timescale 1ns/1ps

module joypad_port import snes_pkg::*; (
  input  logic         clk_sys,
  input  logic         reset,
  input  pad_buttons_t pad1,
  input  pad_buttons_t pad2,
  input  logic         pad_swap,
  input  logic         joy_strb,
  input  logic         joy_clk,
  output logic         joy_do
);

  // pad routed to this port
  pad_buttons_t          pad_sel;
  // buttons in wire order, active low, id bits on top
  logic [PAD_BITS-1:0]   pad_word;
  logic [PAD_BITS-1:0]   shift_q;
  // port clock sync and edge detect
  logic                  clk_q1;
  logic                  clk_q2;
  logic                  clk_rise;

  assign pad_sel = pad_swap ? pad2 : pad1;

  // b goes out first, so it sits at bit 0
  assign pad_word = {
    4'b1111,
    ~pad_sel.r,
    ~pad_sel.l,
    ~pad_sel.x,
    ~pad_sel.a,
    ~pad_sel.right,
    ~pad_sel.left,
    ~pad_sel.down,
    ~pad_sel.up,
    ~pad_sel.start,
    ~pad_sel.select,
    ~pad_sel.y,
    ~pad_sel.b
  };

  // registered compare, one extra cycle before the shift
  assign clk_rise = clk_q1 & ~clk_q2;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      clk_q1 <= 1'b0;
      clk_q2 <= 1'b0;
    end else begin
      clk_q1 <= joy_clk;
      clk_q2 <= clk_q1;
    end
  end

  // latch while strobe is high, shift on port clock otherwise
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      // idle line reads high
      shift_q <= '1;
    end else if (joy_strb) begin
      shift_q <= pad_word;
    end else if (clk_rise) begin
      // zeros shift in, line reads low once all bits are out
      shift_q <= {1'b0, shift_q[PAD_BITS-1:1]};
    end
  end

  // low means pressed
  assign joy_do = shift_q[0];

endmodule

//--- hdl/snes_io_top.sv
`timescale 1ns/1ps

module snes_io_top import snes_pkg::*; (
  input  logic              clk_sys,
  input  logic              reset,
  // cart download
  input  logic              cart_download,
  input  cart_header_t      cart_header,
  input  fill_cfg_t         fill_cfg,
  // controller
  input  pad_buttons_t      pad1,
  input  pad_buttons_t      pad2,
  input  logic              pad_swap,
  input  logic              joy_strb,
  input  logic              joy_clk,
  // core control
  output logic              core_reset_n,
  output logic [MASK_W-1:0] rom_mask,
  output logic [MASK_W-1:0] ram_mask,
  output logic [3:0]        sram_size,
  // ram clear
  output logic              clearing,
  output mem_fill_t         mem_fill,
  output logic              joy_do
);

  // loader to clear, start of a new sweep
  logic clear_start;

  // download edges, parser delay, masks and reset release
  cart_loader u_cart_loader (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .cart_download (cart_download),
    .cart_header   (cart_header),
    .clearing      (clearing),
    .clear_start   (clear_start),
    .core_reset_n  (core_reset_n),
    .rom_mask      (rom_mask),
    .ram_mask      (ram_mask),
    .sram_size     (sram_size)
  );

  // work, audio and battery ram sweep
  ram_clear u_ram_clear (
    .clk_sys     (clk_sys),
    .reset       (reset),
    .clear_start (clear_start),
    .fill_cfg    (fill_cfg),
    .clearing    (clearing),
    .mem_fill    (mem_fill)
  );

  // port 1 serial pad
  joypad_port u_joypad_port (
    .clk_sys  (clk_sys),
    .reset    (reset),
    .pad1     (pad1),
    .pad2     (pad2),
    .pad_swap (pad_swap),
    .joy_strb (joy_strb),
    .joy_clk  (joy_clk),
    .joy_do   (joy_do)
  );

endmodule

//--- sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
  output logic clk_sys,
  output logic reset
);

  // 40 ns period
  initial begin
    clk_sys = 1'b0;
    forever #20 clk_sys = ~clk_sys;
  end

  // active low, held for the first 4 rising edges
  initial begin
    reset = 1'b0;
    repeat (4) @(posedge clk_sys);
    reset <= 1'b1;
  end

endmodule

//--- sim/tb_monitor.sv
`timescale 1ns/1ps

module tb_monitor import snes_pkg::*; (
  input  logic              clk_sys,
  input  logic              reset,
  input  logic              cart_download,
  input  cart_header_t      cart_header,
  input  fill_cfg_t         fill_cfg,
  input  pad_buttons_t      pad1,
  input  pad_buttons_t      pad2,
  input  logic              pad_swap,
  input  logic              joy_strb,
  input  logic              joy_clk,
  input  logic              core_reset_n,
  input  logic [MASK_W-1:0] rom_mask,
  input  logic [MASK_W-1:0] ram_mask,
  input  logic [3:0]        sram_size,
  input  logic              clearing,
  input  mem_fill_t         mem_fill,
  input  logic              joy_do,
  output int                errors
);

  // previous samples for edge detect
  logic              reset_q;
  logic              dl_q;
  logic              clr_q;
  logic              crn_q;
  logic              strb_q;
  logic              jclk_q;
  // header as it stood when the last download ended
  cart_header_t      hdr_seen;
  logic              load_seen;
  logic [MASK_W-1:0] exp_ram;
  // expected parser delay and core reset window
  int                delay_left;
  int                hold_run;
  int                idle_run;
  logic              hold;
  // sweep tracking
  int                exp_addr;
  int                wr_count;
  int                gap;
  // pad read, bit 16 is the idle level after all shifts
  logic [16:0]       pad_exp;
  int                bit_idx;
  int                jclk_wait;
  int                err_cnt = 0;

  assign errors = err_cnt;

  task automatic report_err(input string msg);
    err_cnt++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  // pattern rules per fill setting
  function automatic logic [7:0] pattern_byte(input fill_pattern_e p,
                                              input logic [FILL_ADDR_W-1:0] a);
    if (p == fill_const55)
      return 8'h55;
    if (p == fill_constff)
      return 8'hFF;
    if (p == fill_checker)
      return (a[8] != a[2]) ? 8'h66 : 8'h99;
    return (a[9] != a[0]) ? 8'hFF : 8'h00;
  endfunction

  // size code counts doublings of 1 KiB
  function automatic logic [MASK_W-1:0] size_mask(input logic [3:0] code);
    return (MASK_W'(1) << (int'(code) + 10)) - MASK_W'(1);
  endfunction

  function automatic logic [16:0] serial_word(input pad_buttons_t p);
    logic [11:0] btn;
    logic [16:0] w;
    btn = p;
    // first struct field goes out first, pressed reads low
    for (int i = 0; i < 12; i++)
      w[i] = ~btn[11 - i];
    w[15:12] = 4'hF;
    w[16]    = 1'b0;
    return w;
  endfunction

  task automatic check_pad_bit();
    if (joy_do !== pad_exp[bit_idx])
      report_err($sformatf("joy_do bit %0d is %b, expected %b", bit_idx, joy_do,
                           pad_exp[bit_idx]));
  endtask

  always @(posedge clk_sys) begin
    if (!reset) begin
      load_seen  = 1'b0;
      delay_left = 0;
      hold_run   = 0;
      idle_run   = 0;
      exp_addr   = 0;
      wr_count   = 0;
      gap        = 0;
      bit_idx    = 0;
      jclk_wait  = 0;
      pad_exp    = '1;
    end else begin
      // values left behind by reset
      if (!reset_q) begin
        if (core_reset_n !== 1'b0 || clearing !== 1'b0 || mem_fill.we !== 1'b0 ||
            joy_do !== 1'b1)
          report_err("control outputs not at reset values");
        if (rom_mask !== '0 || ram_mask !== '0 || sram_size !== 4'd0)
          report_err("masks not zero after reset");
      end
      // phase gate lets core_reset_n trail the hold window by up to 4 cycles
      hold = cart_download | clearing | (delay_left != 0);
      if (hold_run >= 4 && core_reset_n)
        report_err("core_reset_n high while a load is running");
      if (idle_run >= 4 && !core_reset_n)
        report_err("core_reset_n still low 4 cycles after the load ended");
      hold_run = hold ? hold_run + 1 : 0;
      idle_run = hold ? 0 : idle_run + 1;
      if (!cart_download && dl_q) begin
        delay_left = PARSER_DELAY;
        hdr_seen   = cart_header;
        load_seen  = 1'b1;
      end else if (delay_left != 0) begin
        delay_left--;
      end
      // masks once the core is released
      if (core_reset_n && !crn_q && load_seen) begin
        exp_ram = (hdr_seen.ram_size == 4'd0) ? '0 : size_mask(hdr_seen.ram_size);
        if (rom_mask !== size_mask(hdr_seen.rom_size))
          report_err($sformatf("rom_mask %h, expected %h", rom_mask,
                               size_mask(hdr_seen.rom_size)));
        if (ram_mask !== exp_ram)
          report_err($sformatf("ram_mask %h, expected %h", ram_mask, exp_ram));
        if (sram_size !== hdr_seen.ram_size)
          report_err($sformatf("sram_size %0d, expected %0d", sram_size,
                               hdr_seen.ram_size));
        // the whole sweep has to be done before the core runs
        if (wr_count != (1 << FILL_ADDR_W))
          report_err($sformatf("core released after %0d of %0d clear writes", wr_count,
                               1 << FILL_ADDR_W));
      end
      // new download, sweep starts over
      if (cart_download && !dl_q) begin
        exp_addr = 0;
        wr_count = 0;
      end
      gap++;
      if (mem_fill.we) begin
        if (mem_fill.addr !== exp_addr[FILL_ADDR_W-1:0])
          report_err($sformatf("fill addr %h, expected %h", mem_fill.addr,
                               exp_addr[FILL_ADDR_W-1:0]));
        if (wr_count > 0 && gap != 4)
          report_err($sformatf("fill writes %0d cycles apart, expected 4", gap));
        if (mem_fill.wram_data !== pattern_byte(fill_cfg.wram_pattern, mem_fill.addr))
          report_err($sformatf("wram_data %h at %h, expected %h", mem_fill.wram_data,
                               mem_fill.addr,
                               pattern_byte(fill_cfg.wram_pattern, mem_fill.addr)));
        if (mem_fill.aram_data !== pattern_byte(fill_cfg.aram_pattern, mem_fill.addr))
          report_err($sformatf("aram_data %h at %h, expected %h", mem_fill.aram_data,
                               mem_fill.addr,
                               pattern_byte(fill_cfg.aram_pattern, mem_fill.addr)));
        if (mem_fill.bsram_data !== BSRAM_FILL)
          report_err($sformatf("bsram_data %h, expected %h", mem_fill.bsram_data,
                               BSRAM_FILL));
        // next write follows this address
        exp_addr = int'(mem_fill.addr) + 1;
        wr_count++;
        gap = 0;
      end
      if (clr_q && !clearing && (wr_count != (1 << FILL_ADDR_W) || gap != 1))
        report_err($sformatf("clear ended after %0d writes", wr_count));
      // bit valid 2 cycles after the port clock rise
      if (jclk_wait > 0) begin
        jclk_wait--;
        if (jclk_wait == 0)
          check_pad_bit();
      end
      if (strb_q && !joy_strb) begin
        pad_exp = serial_word(pad_swap ? pad2 : pad1);
        bit_idx = 0;
        check_pad_bit();
      end
      if (joy_clk && !jclk_q && !joy_strb) begin
        if (bit_idx < PAD_BITS)
          bit_idx++;
        jclk_wait = 2;
      end
    end
    reset_q = reset;
    dl_q    = reset ? cart_download : 1'b0;
    clr_q   = clearing;
    crn_q   = core_reset_n;
    strb_q  = joy_strb;
    jclk_q  = joy_clk;
  end

endmodule

//--- sim/tb_top.sv
`timescale 1ns/1ps

module tb_top import snes_pkg::*; ();

  typedef struct packed {
    cart_header_t hdr;
    fill_cfg_t    cfg;
  } load_row_t;

  typedef struct packed {
    pad_buttons_t p1;
    pad_buttons_t p2;
    logic         swap;
  } pad_row_t;

  localparam int LOAD_ROWS = 4;
  localparam int PAD_ROWS  = 6;
  // full sweep at one write per 4 cycles, plus slack
  localparam int LOAD_LIMIT = 4 * (1 << FILL_ADDR_W) + 200;

  logic              clk_sys;
  logic              reset;
  logic              cart_download;
  cart_header_t      cart_header;
  fill_cfg_t         fill_cfg;
  pad_buttons_t      pad1;
  pad_buttons_t      pad2;
  logic              pad_swap;
  logic              joy_strb;
  logic              joy_clk;
  logic              core_reset_n;
  logic [MASK_W-1:0] rom_mask;
  logic [MASK_W-1:0] ram_mask;
  logic [3:0]        sram_size;
  logic              clearing;
  mem_fill_t         mem_fill;
  logic              joy_do;
  int                errors;
  int                timeouts;
  load_row_t         load_tbl [LOAD_ROWS];
  pad_row_t          pad_tbl [PAD_ROWS];

  clk_gen u_clk_gen (
    .clk_sys (clk_sys),
    .reset   (reset)
  );

  snes_io_top DUT (.*);

  tb_monitor u_monitor (.*);

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_sys);
  endtask

  task automatic wait_core_release(input int limit);
    int n;
    n = 0;
    while (core_reset_n !== 1'b1 && n < limit) begin
      @(posedge clk_sys);
      n++;
    end
    if (core_reset_n !== 1'b1) begin
      $display("timed out after %0d cycles waiting for core_reset_n to rise", limit);
      timeouts++;
    end
  endtask

  // download window, then the sweep and parser delay run on their own
  task automatic run_load(input load_row_t row);
    @(posedge clk_sys);
    cart_header   <= row.hdr;
    fill_cfg      <= row.cfg;
    cart_download <= 1'b1;
    idle_cycles(24);
    cart_download <= 1'b0;
    wait_core_release(LOAD_LIMIT);
    idle_cycles(8);
  endtask

  // strobe, then sixteen port clocks of 3 cycles high and 3 low
  task automatic run_pad_read(input pad_row_t row);
    @(posedge clk_sys);
    pad1     <= row.p1;
    pad2     <= row.p2;
    pad_swap <= row.swap;
    joy_strb <= 1'b1;
    idle_cycles(3);
    joy_strb <= 1'b0;
    idle_cycles(3);
    for (int i = 0; i < PAD_BITS; i++) begin
      joy_clk <= 1'b1;
      idle_cycles(3);
      joy_clk <= 1'b0;
      idle_cycles(3);
    end
    idle_cycles(4);
  endtask

  initial begin
    int          n;
    logic [31:0] r;
    void'($urandom(40764));
    timeouts      = 0;
    cart_download = 1'b0;
    cart_header   = '0;
    fill_cfg      = '0;
    pad1          = '0;
    pad2          = '0;
    pad_swap      = 1'b0;
    joy_strb      = 1'b0;
    joy_clk       = 1'b0;
    // rom code, ram code, wram pattern, aram pattern
    load_tbl[0] = {4'd8, 4'd3, fill_checker, fill_stripe};
    load_tbl[1] = {4'd10, 4'd0, fill_const55, fill_constff};
    load_tbl[2] = {4'd12, 4'd5, fill_stripe, fill_checker};
    load_tbl[3] = {4'd9, 4'd1, fill_constff, fill_const55};
    // pad1, pad2, swap
    pad_tbl[0] = {12'h000, 12'hFFF, 1'b0};
    pad_tbl[1] = {12'hFFF, 12'h000, 1'b0};
    pad_tbl[2] = {12'hFFF, 12'hA5C, 1'b1};
    pad_tbl[3] = {12'h3C3, 12'hC3C, 1'b0};
    for (int i = 4; i < PAD_ROWS; i++) begin
      r = $urandom();
      pad_tbl[i].p1 = r[11:0];
      pad_tbl[i].p2 = r[23:12];
      pad_tbl[i].swap = r[31];
    end
    n = 0;
    while (reset !== 1'b1 && n < 20) begin
      @(posedge clk_sys);
      n++;
    end
    if (reset !== 1'b1) begin
      $display("timed out waiting for reset release");
      timeouts++;
    end
    idle_cycles(8);
    for (int i = 0; i < LOAD_ROWS && timeouts == 0; i++)
      run_load(load_tbl[i]);
    for (int i = 0; i < PAD_ROWS && timeouts == 0; i++)
      run_pad_read(pad_tbl[i]);
    idle_cycles(4);
    $display("run complete: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- vlog.f
common/snes_pkg.sv
hdl/cart_loader.sv
mem_clear/ram_clear.sv
joypad/joypad_port.sv
hdl/snes_io_top.sv
sim/clk_gen.sv
sim/tb_monitor.sv
sim/tb_top.sv
